// ==== Makefile ====
SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_id_stage
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
hw/mips_id_pkg.sv
hw/instr_decoder.sv
hw/operand_fwd.sv
hw/id_ex_reg.sv
hw/id_stage.sv
test/tb_clk_gen.sv
test/id_stage_chk.sv
test/tb_id_stage.sv

// ==== hw/id_ex_reg.sv ====
// ID/EX pipeline register, loads every cycle
// the movn/movz write enable is settled here from the forwarded operand 2
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import mips_id_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  dec_ctrl_t ctrl_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    output id_ex_t    ex_o
);

    logic wreg_d;

    always_comb begin
        case (ctrl_i.wreg_mode)
            WR_ALWAYS:     wreg_d = 1'b1;
            WR_IF_NONZERO: wreg_d = (reg2_i != '0);
            WR_IF_ZERO:    wreg_d = (reg2_i == '0);
            default:       wreg_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_o <= '0;  // NOP bubble
        end else begin
            ex_o.aluop  <= ctrl_i.aluop;
            ex_o.alusel <= ctrl_i.alusel;
            ex_o.reg1   <= reg1_i;
            ex_o.reg2   <= reg2_i;
            ex_o.wd     <= ctrl_i.wd;
            ex_o.wreg   <= wreg_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/id_stage.sv ====
// MIPS32 instruction decode stage
// rf_rd_o is combinational from inst_i and the register file must
// answer reg1_data_i/reg2_data_i in the same cycle
// ex_o is registered, one cycle after inst_i, no stall input
`timescale 1ns/1ps
`default_nettype none

module id_stage import mips_id_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  inst_t    inst_i,
    input  word_t    reg1_data_i,
    input  word_t    reg2_data_i,
    input  fwd_t     ex_fwd_i,
    input  fwd_t     mem_fwd_i,
    output rf_read_t rf_rd_o,
    output id_ex_t   ex_o
);

    dec_ctrl_t dec_ctrl;
    word_t     imm;
    word_t     reg1;
    word_t     reg2;

    instr_decoder dec_i (
        .inst_i  (inst_i),
        .ctrl_o  (dec_ctrl),
        .rf_rd_o (rf_rd_o),
        .imm_o   (imm)
    );

    operand_fwd fwd1 (
        .re_i      (rf_rd_o.re1),
        .addr_i    (rf_rd_o.addr1),
        .rf_data_i (reg1_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg1)
    );

    operand_fwd fwd2 (
        .re_i      (rf_rd_o.re2),
        .addr_i    (rf_rd_o.addr2),
        .rf_data_i (reg2_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg2)
    );

    id_ex_reg pipe_i (
        .clk     (clk),
        .reset_i (reset_i),
        .ctrl_i  (dec_ctrl),
        .reg1_i  (reg1),
        .reg2_i  (reg2),
        .ex_o    (ex_o)
    );

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
// combinational decode of one MIPS32 instruction
// register-register special ops are only decoded with a zero shamt field
// sll/srl/sra need rs = 0 and pass shamt as operand 1
// unknown encodings, sync and pref decode as NOP with no reads and no write
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import mips_id_pkg::*; (
    input  inst_t     inst_i,
    output dec_ctrl_t ctrl_o,
    output rf_read_t  rf_rd_o,
    output word_t     imm_o
);

    opcode_t     opcode;
    funct_t      funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    shamt_t      shamt;
    logic [15:0] imm16;

    alu_op_e op;
    logic    rr_form;   // rs and rt both read
    logic    imm_form;  // rs read, immediate as operand 2
    logic    sh_form;   // fixed shift

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    function automatic alu_op_e rr_op(input funct_t fn);
        case (fn)
            FN_AND:  rr_op = ALU_AND;
            FN_OR:   rr_op = ALU_OR;
            FN_XOR:  rr_op = ALU_XOR;
            FN_NOR:  rr_op = ALU_NOR;
            FN_SLLV: rr_op = ALU_SLL;
            FN_SRLV: rr_op = ALU_SRL;
            FN_SRAV: rr_op = ALU_SRA;
            FN_ADD:  rr_op = ALU_ADD;
            FN_ADDU: rr_op = ALU_ADDU;
            FN_SUB:  rr_op = ALU_SUB;
            FN_SUBU: rr_op = ALU_SUBU;
            FN_SLT:  rr_op = ALU_SLT;
            FN_SLTU: rr_op = ALU_SLTU;
            FN_MOVN: rr_op = ALU_MOVN;
            FN_MOVZ: rr_op = ALU_MOVZ;
            FN_SYNC: rr_op = ALU_NOP;  // no memory ordering here
            default: rr_op = ALU_NOP;
        endcase
    endfunction

    function automatic alu_sel_e sel_of(input alu_op_e aop);
        case (aop)
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: sel_of = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         sel_of = SEL_SHIFT;
            ALU_MOVN, ALU_MOVZ:                sel_of = SEL_MOVE;
            ALU_NOP:                           sel_of = SEL_NOP;
            default:                           sel_of = SEL_ARITH;
        endcase
    endfunction

    always_comb begin
        op       = ALU_NOP;
        rr_form  = 1'b0;
        imm_form = 1'b0;
        sh_form  = 1'b0;
        imm_o    = '0;

        case (opcode)
            OP_SPECIAL: begin
                if (shamt == '0) begin
                    op      = rr_op(funct);
                    rr_form = (op != ALU_NOP);
                end
                if (rs == '0) begin
                    sh_form = 1'b1;
                    case (funct)
                        FN_SLL:  op = ALU_SLL;
                        FN_SRL:  op = ALU_SRL;
                        FN_SRA:  op = ALU_SRA;
                        default: sh_form = 1'b0;
                    endcase
                    if (sh_form) begin
                        imm_o = {27'h0, shamt};
                    end
                end
            end
            OP_ANDI: begin
                op       = ALU_AND;
                imm_form = 1'b1;
                imm_o    = {16'h0, imm16};
            end
            OP_ORI: begin
                op       = ALU_OR;
                imm_form = 1'b1;
                imm_o    = {16'h0, imm16};
            end
            OP_XORI: begin
                op       = ALU_XOR;
                imm_form = 1'b1;
                imm_o    = {16'h0, imm16};
            end
            OP_LUI: begin
                op       = ALU_OR;  // rs | (imm << 16)
                imm_form = 1'b1;
                imm_o    = {imm16, 16'h0};
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                case (opcode)
                    OP_ADDI:  op = ALU_ADD;
                    OP_ADDIU: op = ALU_ADDU;
                    OP_SLTI:  op = ALU_SLT;
                    default:  op = ALU_SLTU;
                endcase
                imm_form = 1'b1;
                imm_o    = {{16{imm16[15]}}, imm16};
            end
            OP_PREF: op = ALU_NOP;  // hint only
            default: op = ALU_NOP;
        endcase

        ctrl_o.aluop  = op;
        ctrl_o.alusel = sel_of(op);
        ctrl_o.wd     = imm_form ? rt : rd;
        case (op)
            ALU_NOP:  ctrl_o.wreg_mode = WR_NEVER;
            ALU_MOVN: ctrl_o.wreg_mode = WR_IF_NONZERO;
            ALU_MOVZ: ctrl_o.wreg_mode = WR_IF_ZERO;
            default:  ctrl_o.wreg_mode = WR_ALWAYS;
        endcase

        rf_rd_o.re1   = rr_form | imm_form;
        rf_rd_o.addr1 = rs;
        rf_rd_o.re2   = rr_form | sh_form;
        rf_rd_o.addr2 = rt;
    end

endmodule

`default_nettype wire

// ==== hw/mips_id_pkg.sv ====
// types and encodings shared by the MIPS32 decode stage
// covers the integer logic, shift, arithmetic and conditional move subset only
// alu_op_e uses all 16 codes so a new op needs a wider type
`default_nettype none

package mips_id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_PREF    = 6'b110011;

    // special function codes
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_MOVZ = 6'b001010;
    localparam funct_t FN_MOVN = 6'b001011;
    localparam funct_t FN_SYNC = 6'b001111;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_SLT,
        ALU_SLTU,
        ALU_MOVN,
        ALU_MOVZ
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP = 3'd0,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_MOVE
    } alu_sel_e;

    typedef enum logic [1:0] {
        WR_NEVER = 2'd0,
        WR_ALWAYS,
        WR_IF_NONZERO,  // movn
        WR_IF_ZERO      // movz
    } wreg_mode_e;

    typedef struct packed {
        logic      re1;
        reg_addr_t addr1;
        logic      re2;
        reg_addr_t addr2;
    } rf_read_t;

    // pending write of a later stage
    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
    } id_ex_t;

    typedef struct packed {
        alu_op_e    aluop;
        alu_sel_e   alusel;
        reg_addr_t  wd;
        wreg_mode_e wreg_mode;
    } dec_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/operand_fwd.sv ====
// operand source select for one read port
// priority is execute, then memory, then register file
// register 0 is forwarded like any other register
`timescale 1ns/1ps
`default_nettype none

module operand_fwd import mips_id_pkg::*; (
    input  logic      re_i,
    input  reg_addr_t addr_i,
    input  word_t     rf_data_i,
    input  word_t     imm_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    always_comb begin
        if (!re_i) begin
            operand_o = imm_i;  // port not read
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== test/id_stage_chk.sv ====
// concurrent checks on the ID/EX register, bound into id_ex_reg
// a NOP must never carry a register write
`timescale 1ns/1ps
`default_nettype none

module id_stage_chk import mips_id_pkg::*; (
    input logic   clk,
    input logic   reset_i,
    input id_ex_t ex_i
);

    reset_clears: assert property (@(posedge clk)
        reset_i |=> (!ex_i.wreg && ex_i.aluop == ALU_NOP))
        else $error("ID/EX not cleared in the cycle after reset");

    nop_op_no_write: assert property (@(posedge clk)
        (ex_i.aluop == ALU_NOP) |-> !ex_i.wreg)
        else $error("aluop NOP with a register write");

    nop_sel_no_write: assert property (@(posedge clk)
        (ex_i.alusel == SEL_NOP) |-> !ex_i.wreg)
        else $error("alusel NOP with a register write");

endmodule

bind id_ex_reg id_stage_chk chk_i (
    .clk     (clk),
    .reset_i (reset_i),
    .ex_i    (ex_o)
);

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
// clock and reset for the decode stage testbench
// 40 ns period, reset_o high for the first 10 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int half_period_ns = 20;
    localparam int reset_cycles   = 10;

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        forever #(half_period_ns) clk_o = ~clk_o;
    end

    initial begin
        repeat (reset_cycles) @(posedge clk_o);
        reset_o <= 1'b0;  // released after the 10th edge
    end

endmodule

`default_nettype wire

// ==== test/tb_id_stage.sv ====
// testbench for id_stage with a combinational register file model
// expected ID/EX values come from a reference decoder in this file
// inputs change on the falling edge, ex_o is compared on the next one
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import mips_id_pkg::*; ();

    localparam int rand_count   = 200;
    localparam int directed_max = 64;
    localparam int test_count   = 6;
    localparam int total_cycles = 10 + directed_max + rand_count + 2 * test_count;
    localparam int timeout_ns   = (total_cycles + 50) * 40;

    localparam funct_t rr_fns [15] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV,
        FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_MOVN, FN_MOVZ};
    localparam opcode_t imm_ops [8] = '{OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
    localparam funct_t sh_fns [3] = '{FN_SLL, FN_SRL, FN_SRA};

    logic     clk;
    logic     reset_i;
    inst_t    inst;
    fwd_t     ex_fwd;
    fwd_t     mem_fwd;
    rf_read_t rf_rd;
    id_ex_t   ex_o;
    word_t    rf [32];
    word_t    reg1_data;
    word_t    reg2_data;

    id_ex_t   pend_exp;
    rf_read_t pend_rd;
    logic     pend_valid;
    id_ex_t   cur_exp;
    logic     cur_valid = 1'b0;
    int       checks = 0;
    int       errors = 0;
    int       check_base = 0;
    int       error_base = 0;
    int       tests_done = 0;

    tb_clk_gen clk_gen_i (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    id_stage dut_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .inst_i      (inst),
        .reg1_data_i (reg1_data),
        .reg2_data_i (reg2_data),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd),
        .rf_rd_o     (rf_rd),
        .ex_o        (ex_o)
    );

    assign reg1_data = rf[rf_rd.addr1];  // same-cycle register file
    assign reg2_data = rf[rf_rd.addr2];

    function automatic inst_t make_rtype(input funct_t fn, input reg_addr_t rs,
                                         input reg_addr_t rt, input reg_addr_t rd,
                                         input shamt_t sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic inst_t make_itype(input opcode_t op, input reg_addr_t rs,
                                         input reg_addr_t rt, input logic [15:0] k);
        return {op, rs, rt, k};
    endfunction

    function automatic fwd_t make_fwd(input logic w, input reg_addr_t a, input word_t d);
        fwd_t f;
        f.wreg  = w;
        f.wd    = a;
        f.wdata = d;
        return f;
    endfunction

    // execute beats memory beats register file, immediate when not read
    function automatic word_t pick_operand(input logic rd_en, input reg_addr_t a,
                                           input word_t rf_val, input word_t imm,
                                           input fwd_t exf, input fwd_t memf);
        if (!rd_en)
            return imm;
        if (exf.wreg && exf.wd == a)
            return exf.wdata;
        if (memf.wreg && memf.wd == a)
            return memf.wdata;
        return rf_val;
    endfunction

    function automatic id_ex_t expected_id_ex(input inst_t ins, input word_t regs [32],
                                              input fwd_t exf, input fwd_t memf,
                                              output rf_read_t rq);
        opcode_t     opc;
        funct_t      fn;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        shamt_t      sh;
        logic [15:0] k;
        alu_op_e     op;
        logic        rd1;
        logic        rd2;
        word_t       imm;
        reg_addr_t   dst;
        id_ex_t      r;
        opc = ins[31:26];
        rs  = ins[25:21];
        rt  = ins[20:16];
        rd  = ins[15:11];
        sh  = ins[10:6];
        fn  = ins[5:0];
        k   = ins[15:0];
        op  = ALU_NOP;
        rd1 = 1'b0;
        rd2 = 1'b0;
        imm = '0;
        dst = rd;
        if (opc == OP_SPECIAL) begin
            if (rs == 5'd0 && fn inside {FN_SLL, FN_SRL, FN_SRA}) begin
                case (fn)
                    FN_SLL:  op = ALU_SLL;
                    FN_SRL:  op = ALU_SRL;
                    default: op = ALU_SRA;
                endcase
                rd2 = 1'b1;
                imm = {27'd0, sh};  // shamt as operand 1
            end else if (sh == 5'd0) begin
                rd1 = 1'b1;
                rd2 = 1'b1;
                case (fn)
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_NOR:  op = ALU_NOR;
                    FN_SLLV: op = ALU_SLL;
                    FN_SRLV: op = ALU_SRL;
                    FN_SRAV: op = ALU_SRA;
                    FN_ADD:  op = ALU_ADD;
                    FN_ADDU: op = ALU_ADDU;
                    FN_SUB:  op = ALU_SUB;
                    FN_SUBU: op = ALU_SUBU;
                    FN_SLT:  op = ALU_SLT;
                    FN_SLTU: op = ALU_SLTU;
                    FN_MOVN: op = ALU_MOVN;
                    FN_MOVZ: op = ALU_MOVZ;
                    default: begin
                        rd1 = 1'b0;
                        rd2 = 1'b0;
                    end
                endcase
            end
        end else begin
            rd1 = 1'b1;
            dst = rt;
            case (opc)
                OP_ANDI: begin op = ALU_AND; imm = {16'd0, k}; end
                OP_ORI: begin op = ALU_OR; imm = {16'd0, k}; end
                OP_XORI: begin op = ALU_XOR; imm = {16'd0, k}; end
                OP_LUI: begin op = ALU_OR; imm = {k, 16'd0}; end
                OP_ADDI: begin op = ALU_ADD; imm = {{16{k[15]}}, k}; end
                OP_ADDIU: begin op = ALU_ADDU; imm = {{16{k[15]}}, k}; end
                OP_SLTI: begin op = ALU_SLT; imm = {{16{k[15]}}, k}; end
                OP_SLTIU: begin op = ALU_SLTU; imm = {{16{k[15]}}, k}; end
                default: begin
                    rd1 = 1'b0;
                    dst = rd;
                end
            endcase
        end
        r.aluop = op;
        case (op)
            ALU_NOP:                             r.alusel = SEL_NOP;
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR:   r.alusel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:           r.alusel = SEL_SHIFT;
            ALU_MOVN, ALU_MOVZ:                  r.alusel = SEL_MOVE;
            default:                             r.alusel = SEL_ARITH;
        endcase
        r.reg1 = pick_operand(rd1, rs, regs[rs], imm, exf, memf);
        r.reg2 = pick_operand(rd2, rt, regs[rt], imm, exf, memf);
        r.wd   = dst;
        case (op)
            ALU_NOP:  r.wreg = 1'b0;
            ALU_MOVN: r.wreg = (r.reg2 != '0);
            ALU_MOVZ: r.wreg = (r.reg2 == '0);
            default:  r.wreg = 1'b1;
        endcase
        rq.re1   = rd1;
        rq.addr1 = rs;
        rq.re2   = rd2;
        rq.addr2 = rt;
        return r;
    endfunction

    function automatic inst_t random_inst();
        int        kind;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        kind = $urandom % 5;
        rs   = 5'($urandom % 8);  // small range so forwarding hits
        rt   = 5'($urandom % 8);
        rd   = 5'($urandom % 8);
        case (kind)
            0: return $urandom;
            1: return make_rtype(rr_fns[$urandom % 15], rs, rt, rd, 5'd0);
            2: return make_itype(imm_ops[$urandom % 8], rs, rt, 16'($urandom));
            3: return make_rtype(sh_fns[$urandom % 3], 5'd0, rt, rd, 5'($urandom));
            default: return make_rtype(6'($urandom), rs, rt, rd, 5'($urandom % 2));
        endcase
    endfunction

    function automatic fwd_t random_fwd();
        word_t d;
        d = ($urandom % 4 == 0) ? '0 : $urandom;
        return make_fwd(1'($urandom), 5'($urandom % 8), d);
    endfunction

    task automatic apply(input inst_t ins, input fwd_t exf, input fwd_t memf);
        id_ex_t   e;
        rf_read_t q;
        @(negedge clk);
        inst    = ins;
        ex_fwd  = exf;
        mem_fwd = memf;
        e = expected_id_ex(ins, rf, exf, memf, q);
        if (reset_i)
            pend_exp = '0;
        else
            pend_exp = e;
        pend_rd    = q;  // read requests follow inst even in reset
        pend_valid = 1'b1;
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        pend_valid = 1'b0;
        @(negedge clk);  // last item compared by now
        $display("%-10s %0d checks, %0d errors", name, checks - check_base,
                 errors - error_base);
        check_base = checks;
        error_base = errors;
        tests_done++;
    endtask

    task automatic compare_field(input string field, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        assert (exp_v === act_v) else begin
            $display("** Error %0t ns: %s expected 0x%0h got 0x%0h",
                     $time, field, exp_v, act_v);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        cur_valid <= pend_valid;
        cur_exp   <= pend_exp;
        if (pend_valid) begin  // inst stable since the falling edge
            compare_field("rf_rd_o.re1", 32'(pend_rd.re1), 32'(rf_rd.re1));
            compare_field("rf_rd_o.addr1", 32'(pend_rd.addr1), 32'(rf_rd.addr1));
            compare_field("rf_rd_o.re2", 32'(pend_rd.re2), 32'(rf_rd.re2));
            compare_field("rf_rd_o.addr2", 32'(pend_rd.addr2), 32'(rf_rd.addr2));
        end
    end

    always @(negedge clk) begin
        if (cur_valid) begin
            compare_field("ex_o.aluop", 32'(cur_exp.aluop), 32'(ex_o.aluop));
            compare_field("ex_o.alusel", 32'(cur_exp.alusel), 32'(ex_o.alusel));
            compare_field("ex_o.reg1", cur_exp.reg1, ex_o.reg1);
            compare_field("ex_o.reg2", cur_exp.reg2, ex_o.reg2);
            compare_field("ex_o.wd", 32'(cur_exp.wd), 32'(ex_o.wd));
            compare_field("ex_o.wreg", 32'(cur_exp.wreg), 32'(ex_o.wreg));
            checks++;
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        fwd_t  nf;
        inst_t add_i;
        inst   = '0;
        ex_fwd = '0;
        mem_fwd = '0;
        pend_exp = '0;
        pend_rd = '0;
        pend_valid = 1'b0;
        nf = '0;
        void'($urandom(59210));
        for (int i = 0; i < 32; i++)
            rf[i] = $urandom;

        // reset holds ex_o at zero, then three items load normally
        repeat (12) apply(make_itype(OP_ORI, 5'd3, 5'd7, 16'hbeef), nf, nf);
        finish_test("reset");

        for (int i = 0; i < 13; i++)
            apply(make_rtype(rr_fns[i], 5'd3, 5'd7, 5'd12, 5'd0), nf, nf);
        finish_test("reg_reg");

        for (int i = 0; i < 8; i++)
            apply(make_itype(imm_ops[i], 5'd3, 5'd7, (i % 2 == 0) ? 16'h8a5c : 16'h1234),
                  nf, nf);
        for (int i = 0; i < 3; i++)
            apply(make_rtype(sh_fns[i], 5'd0, 5'd7, 5'd12, 5'd13), nf, nf);
        finish_test("immediate");

        add_i = make_rtype(FN_ADD, 5'd3, 5'd7, 5'd12, 5'd0);
        apply(add_i, make_fwd(1'b1, 5'd7, 32'h1111_0000), make_fwd(1'b1, 5'd7, 32'h2222_0000));
        apply(add_i, nf, make_fwd(1'b1, 5'd7, 32'h2222_0000));
        apply(add_i, nf, nf);
        apply(add_i, make_fwd(1'b0, 5'd7, 32'h1111_0000), make_fwd(1'b1, 5'd7, 32'h2222_0000));
        apply(add_i, make_fwd(1'b1, 5'd3, 32'h3333_0000), make_fwd(1'b1, 5'd7, 32'h4444_0000));
        apply(add_i, make_fwd(1'b1, 5'd3, 32'h5555_0000), make_fwd(1'b1, 5'd3, 32'h6666_0000));
        finish_test("forwarding");

        apply(make_rtype(FN_MOVN, 5'd3, 5'd7, 5'd12, 5'd0), make_fwd(1'b1, 5'd7, '0), nf);
        apply(make_rtype(FN_MOVN, 5'd3, 5'd7, 5'd12, 5'd0), make_fwd(1'b1, 5'd7, 32'h9), nf);
        apply(make_rtype(FN_MOVZ, 5'd3, 5'd7, 5'd12, 5'd0), nf, make_fwd(1'b1, 5'd7, '0));
        apply(make_rtype(FN_MOVZ, 5'd3, 5'd7, 5'd12, 5'd0), nf, nf);
        apply(make_rtype(FN_MOVZ, 5'd3, 5'd7, 5'd12, 5'd0), make_fwd(1'b1, 5'd7, 32'h5),
              make_fwd(1'b1, 5'd7, '0));
        apply(make_rtype(FN_MOVN, 5'd3, 5'd7, 5'd12, 5'd0), nf, nf);
        finish_test("cond_move");

        apply({6'h3f, 26'h123_4567}, nf, nf);
        apply(make_rtype(FN_SYNC, 5'd0, 5'd0, 5'd0, 5'd0), nf, nf);
        apply(make_itype(OP_PREF, 5'd3, 5'd7, 16'h0040), nf, nf);
        apply(make_rtype(6'h3e, 5'd3, 5'd7, 5'd12, 5'd0), nf, nf);
        apply(make_rtype(FN_ADD, 5'd3, 5'd7, 5'd12, 5'd4), nf, nf);
        for (int i = 0; i < rand_count; i++)
            apply(random_inst(), random_fwd(), random_fwd());
        finish_test("random");

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
